/* all.f */
common/fpu_pkg.sv
hdl/iter_counter.sv
hdl/fpu_ctrl.sv
addsub/fp_addsub.sv
mul/booth_mul.sv
div/mant_div.sv
hdl/result_sel.sv
hdl/fpu_top.sv
sim/fpu_props.sv
sim/fpu_checker.sv
sim/fpu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fpu_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
FILELIST  ?= all.f
PASS_MSG  ?= *** PASSED ***

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -F '$(PASS_MSG)' > /dev/null

clean:
	rm -rf $(OBJ_DIR)

/* sim/fpu_tb.sv */
module fpu_tb import fpu_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int RST_CYCLES = 16;
	localparam int N_OPS      = 3000;
	localparam int LIMIT      = N_OPS * (DIV_ITER + 4) + RST_CYCLES + 100;

	logic        clk;
	logic        arst_n;
	logic        start;
	op_e         op;
	fp32_t       a;
	fp32_t       b;
	fp32_t       result;
	fp_flags_t   flags;
	logic        done;
	logic        busy;
	int          n_err;
	int          n_done;
	logic [31:0] rng;

	fpu_top u_fpu_top (
		.clk      (clk),
		.i_arst_n (arst_n),
		.i_start  (start),
		.i_op     (op),
		.i_a      (a),
		.i_b      (b),
		.o_result (result),
		.o_flags  (flags),
		.o_done   (done),
		.o_busy   (busy)
	);

	fpu_checker u_checker (
		.clk        (clk),
		.i_arst_n   (arst_n),
		.i_start    (start),
		.i_op       (op),
		.i_a        (a),
		.i_b        (b),
		.i_result   (result),
		.i_flags    (flags),
		.i_done     (done),
		.i_busy     (busy),
		.o_err_cnt  (n_err),
		.o_done_cnt (n_done)
	);

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic draw(output logic [31:0] v);
		rng = xorshift32(rng);
		v   = rng;
	endtask

	task automatic rand_operand(output fp32_t v);
		logic [31:0] r;
		draw(r);
		v.sign = r[31];
		v.exp  = 8'(1 + int'(r[30:23]) % 254);
		v.man  = r[22:0];
	endtask

	task automatic run_op(input op_e o, input fp32_t x, input fp32_t y);
		logic [31:0] r;
		int          k;
		start = 1'b1;
		op    = o;
		a     = x;
		b     = y;
		@(negedge clk);
		start = 1'b0;
		draw(r);
		if (o == OP_DIV && r[0]) begin
			k = 1 + int'(r[8:4]) % 20; // stray start well inside the divide
			repeat (k) @(negedge clk);
			start = 1'b1;
			op    = op_e'(r[13:12]);
			a     = r;
			b     = ~r;
			@(negedge clk);
			start = 1'b0;
		end
		while (!done)
			@(negedge clk);
		draw(r);
		repeat (int'(r[1:0]) % 3) @(negedge clk);
	endtask

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the test did not finish", LIMIT);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		logic [31:0] r;
		op_e         o;
		logic [2:0]  m;
		fp32_t       x;
		fp32_t       y;
		rng    = 32'h0182_b810;
		arst_n = 1'b0;
		start  = 1'b0;
		op     = OP_ADD;
		a      = '0;
		b      = '0;
		repeat (RST_CYCLES) @(negedge clk);
		arst_n = 1'b1;
		repeat (3) @(negedge clk); // idle outputs after reset
		for (int i = 0; i < N_OPS; i++) begin
			draw(r);
			o = op_e'(r[1:0]);
			m = r[4:2];
			rand_operand(x);
			rand_operand(y);
			case (o)
				OP_ADD, OP_SUB: begin
					if (m == 3'd0) begin
						y      = x; // exact cancellation
						y.sign = x.sign ^ (o == OP_ADD);
					end else if (m == 3'd1) begin
						y.exp = x.exp;
						y.man = x.man ^ {18'd0, r[9:5]}; // deep normalisation
					end else if (m == 3'd2 && x.exp > 8'd3) begin
						y.exp = x.exp - {6'd0, r[6:5]};
					end
				end
				OP_MUL: begin
					if (m == 3'd0) begin
						x.exp = 8'(200 + int'(r[12:7]) % 55);
						y.exp = 8'(200 + int'(r[18:13]) % 55);
					end else if (m == 3'd1) begin
						x.exp = 8'(1 + int'(r[12:7]) % 60);
						y.exp = 8'(1 + int'(r[18:13]) % 60);
					end
				end
				default: begin
					if (m == 3'd0 || m == 3'd1)
						y = {y.sign, 31'd0}; // zero divisor
					if (m == 3'd1)
						x = {x.sign, 31'd0};
					if (m == 3'd2) begin
						x.exp = 8'(200 + int'(r[12:7]) % 55);
						y.exp = 8'(1 + int'(r[18:13]) % 60);
					end else if (m == 3'd3) begin
						x.exp = 8'(1 + int'(r[12:7]) % 60);
						y.exp = 8'(200 + int'(r[18:13]) % 55);
					end
				end
			endcase
			run_op(o, x, y);
		end
		repeat (4) @(negedge clk);
		$display("errors: %0d, results checked: %0d of %0d", n_err, n_done, N_OPS);
		if (n_err == 0 && n_done == N_OPS) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

/* sim/fpu_checker.sv */
module fpu_checker import fpu_pkg::*; (
	input  logic      clk,
	input  logic      i_arst_n,
	input  logic      i_start,
	input  op_e       i_op,
	input  fp32_t     i_a,
	input  fp32_t     i_b,
	input  fp32_t     i_result,
	input  fp_flags_t i_flags,
	input  logic      i_done,
	input  logic      i_busy,
	output int        o_err_cnt,
	output int        o_done_cnt
);
	timeunit 1ns;
	timeprecision 100ps;

	fp_result_t want_q;
	fp32_t      a_q;
	fp32_t      b_q;
	op_e        op_q;
	logic       pend_q;
	logic       seen_start;
	int         cyc;
	int         want_cyc;

	// inf or signed zero outside exponents 1..254
	function automatic fp_result_t saturate(input logic s, input int e, input logic [22:0] m);
		fp_result_t r;
		r = '0;
		r.val.sign = s;
		if (e > 254) begin
			r.val.exp   = 8'hff;
			r.flags.ovf = 1'b1;
		end else if (e < 1) begin
			r.flags.unf = 1'b1;
		end else begin
			r.val.exp = 8'(e);
			r.val.man = m;
		end
		return r;
	endfunction

	function automatic fp_result_t model_addsub(input op_e op, input fp32_t a, input fp32_t b);
		fp32_t       bx;
		fp32_t       big;
		fp32_t       little;
		int          d;
		int          k;
		logic [23:0] sn;
		logic [24:0] s;
		bx      = b;
		bx.sign = b.sign ^ (op == OP_SUB);
		if ({a.exp, a.man} >= {bx.exp, bx.man}) begin
			big    = a;
			little = bx;
		end else begin
			big    = bx;
			little = a;
		end
		if (big.sign != little.sign && {big.exp, big.man} == {little.exp, little.man})
			return '0; // exact cancellation
		d  = int'(big.exp) - int'(little.exp);
		sn = (d >= 24) ? 24'd0 : ({1'b1, little.man} >> d);
		if (big.sign == little.sign) begin
			s = {2'b01, big.man} + {1'b0, sn};
			if (s[24])
				return saturate(big.sign, int'(big.exp) + 1, s[23:1]);
			return saturate(big.sign, int'(big.exp), s[22:0]);
		end
		s = {2'b01, big.man} - {1'b0, sn};
		k = 0;
		while (!s[23]) begin
			s = s << 1;
			k++;
		end
		return saturate(big.sign, int'(big.exp) - k, s[22:0]);
	endfunction

	function automatic fp_result_t model_mul(input fp32_t a, input fp32_t b);
		logic [47:0] p;
		int          e;
		p = {24'd0, 1'b1, a.man} * {24'd0, 1'b1, b.man};
		e = int'(a.exp) + int'(b.exp) - 127;
		if (p[47])
			return saturate(a.sign ^ b.sign, e + 1, p[46:24]);
		return saturate(a.sign ^ b.sign, e, p[45:23]);
	endfunction

	function automatic fp_result_t model_div(input fp32_t a, input fp32_t b);
		fp_result_t  r;
		logic [48:0] q;
		int          e;
		r = '0;
		if ({b.exp, b.man} == 31'd0) begin
			if ({a.exp, a.man} == 31'd0)
				r.flags.zbz = 1'b1;
			else
				r.flags.dbz = 1'b1;
			return r;
		end
		q = {1'b1, a.man, 24'd0} / {25'd0, 1'b1, b.man}; // fits in 25 bits
		e = int'(a.exp) - int'(b.exp) + 127;
		if (q[24])
			return saturate(a.sign ^ b.sign, e, q[23:1]);
		return saturate(a.sign ^ b.sign, e - 1, q[22:0]);
	endfunction

	task automatic problem(input string msg);
		o_err_cnt++;
		$display("%0t ns: %s", $time, msg);
	endtask

	always @(posedge clk) begin
		if (!i_arst_n) begin
			pend_q     = 1'b0;
			seen_start = 1'b0;
			o_err_cnt  = 0;
			o_done_cnt = 0;
		end else begin
			if (o_done_cnt == 0 && !i_done && (i_result !== '0 || i_flags !== '0))
				problem("output is not zero before the first result");
			if (!seen_start && (i_done || i_busy))
				problem("o_done or o_busy is high before any start");
			if (pend_q) begin
				cyc++;
				if (i_done) begin
					if (cyc != want_cyc)
						problem($sformatf("o_done came %0d cycles after the %s start, expected %0d",
							cyc, op_q.name(), want_cyc));
					if (i_busy)
						problem("o_busy is still high together with o_done");
					if (i_result !== want_q.val || i_flags !== want_q.flags) begin
						o_err_cnt++;
						$display("[FAIL] %0t ns %s a=%h b=%h got %h flags %b, expected %h flags %b",
							$time, op_q.name(), a_q, b_q, i_result, i_flags,
							want_q.val, want_q.flags);
					end
					o_done_cnt++;
					pend_q = 1'b0;
				end else if (cyc >= want_cyc) begin
					problem($sformatf("no o_done %0d cycles after the %s start", cyc, op_q.name()));
					pend_q = 1'b0;
				end else if (op_q == OP_DIV && !i_busy) begin
					problem("o_busy went low while the divide was running");
				end
			end else if (i_done) begin
				problem("o_done without an accepted start");
			end
			// starts while busy are ignored by the DUT
			if (i_start && !i_busy) begin
				seen_start = 1'b1;
				pend_q     = 1'b1;
				cyc        = 0;
				op_q       = i_op;
				a_q        = i_a;
				b_q        = i_b;
				want_cyc   = (i_op == OP_DIV) ? DIV_ITER + 2 : 1; // one edge past the capture
				case (i_op)
					OP_MUL:  want_q = model_mul(i_a, i_b);
					OP_DIV:  want_q = model_div(i_a, i_b);
					default: want_q = model_addsub(i_op, i_a, i_b);
				endcase
			end
		end
	end

endmodule

/* sim/fpu_props.sv */
module fpu_props import fpu_pkg::*; (
	input logic        clk,
	input logic        i_arst_n,
	input logic        i_start,
	input op_e         i_op,
	input logic        i_last,
	input ctrl_state_e i_state,
	input logic        i_load,
	input logic        i_capture,
	input logic        i_busy
);
	timeunit 1ns;
	timeprecision 100ps;

	// single-cycle op from idle, or the cycle after the last divide step
	capture_src: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_capture |-> ((i_state == ST_IDLE) ? (i_start && i_op != OP_DIV)
			: (i_state == ST_FINISH && $past(i_state == ST_DIVIDE && i_last))))
		else $error("capture outside an idle single-cycle start or ST_FINISH");

	busy_fall: assert property (@(posedge clk) disable iff (!i_arst_n)
		$fell(i_busy) |-> $past(i_capture))
		else $error("o_busy fell without a capture");

	// a new divide only after an idle cycle or a finished result
	load_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
		i_load |-> !i_busy && (!$past(i_busy) || $past(i_capture)))
		else $error("divide load while busy");

endmodule

bind fpu_ctrl fpu_props u_fpu_props (
	.clk       (clk),
	.i_arst_n  (i_arst_n),
	.i_start   (i_start),
	.i_op      (i_op),
	.i_last    (i_last),
	.i_state   (state_q),
	.i_load    (o_load),
	.i_capture (o_capture),
	.i_busy    (o_busy)
);

/* hdl/fpu_top.sv */
module fpu_top import fpu_pkg::*; (
	input  logic      clk,
	input  logic      i_arst_n,
	input  logic      i_start,
	input  op_e       i_op,
	input  fp32_t     i_a,
	input  fp32_t     i_b,
	output fp32_t     o_result,
	output fp_flags_t o_flags,
	output logic      o_done,
	output logic      o_busy
);

	logic       load;
	logic       step;
	logic       capture;
	logic       last;
	op_e        sel;
	fp_result_t addsub_res;
	fp_result_t mul_res;
	fp_result_t div_res;

	fpu_ctrl u_fpu_ctrl (
		.clk       (clk),
		.i_arst_n  (i_arst_n),
		.i_start   (i_start),
		.i_op      (i_op),
		.i_last    (last),
		.o_load    (load),
		.o_step    (step),
		.o_capture (capture),
		.o_sel     (sel),
		.o_busy    (o_busy)
	);

	iter_counter u_iter_counter (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_clear  (load),
		.i_en     (step),
		.o_last   (last)
	);

	fp_addsub u_fp_addsub (
		.i_a   (i_a),
		.i_b   (i_b),
		.i_op  (i_op),
		.o_res (addsub_res)
	);

	booth_mul u_booth_mul (
		.i_a   (i_a),
		.i_b   (i_b),
		.o_res (mul_res)
	);

	mant_div u_mant_div (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_load   (load),
		.i_step   (step),
		.i_a      (i_a),
		.i_b      (i_b),
		.o_res    (div_res)
	);

	result_sel u_result_sel (
		.clk       (clk),
		.i_arst_n  (i_arst_n),
		.i_capture (capture),
		.i_sel     (sel),
		.i_addsub  (addsub_res),
		.i_mul     (mul_res),
		.i_div     (div_res),
		.o_result  (o_result),
		.o_flags   (o_flags),
		.o_done    (o_done)
	);

endmodule

/* hdl/result_sel.sv */
module result_sel import fpu_pkg::*; (
	input  logic       clk,
	input  logic       i_arst_n,
	input  logic       i_capture,
	input  op_e        i_sel,
	input  fp_result_t i_addsub,
	input  fp_result_t i_mul,
	input  fp_result_t i_div,
	output fp32_t      o_result,
	output fp_flags_t  o_flags,
	output logic       o_done
);

	fp_result_t chosen;

	always_comb begin
		case (i_sel)
			OP_ADD, OP_SUB: chosen = i_addsub;
			OP_MUL:         chosen = i_mul;
			default:        chosen = i_div;
		endcase
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_result <= '0;
			o_flags  <= '0;
			o_done   <= 1'b0;
		end else begin
			o_done <= i_capture; // one cycle after capture
			if (i_capture) begin
				o_result <= chosen.val;
				o_flags  <= chosen.flags;
			end
		end
	end

endmodule

/* div/mant_div.sv */
module mant_div import fpu_pkg::*; (
	input  logic       clk,
	input  logic       i_arst_n,
	input  logic       i_load,
	input  logic       i_step,
	input  fp32_t      i_a,
	input  fp32_t      i_b,
	output fp_result_t o_res
);

	logic                     sign_q;
	logic [EXP_W-1:0]         exp_a_q;
	logic [EXP_W-1:0]         exp_b_q;
	logic                     a_zero_q;
	logic                     b_zero_q;
	logic [SIG_W:0]           quo_q;
	logic [SIG_W-1:0]         dvsr_q;
	logic [SIG_W:0]           rem_q;
	logic [SIG_W:0]           rem_sub;
	logic                     q_bit;
	logic signed [XEXP_W-1:0] exp_res;
	logic [MAN_W-1:0]         man_res;
	fp_result_t               norm_res;

	// one restoring step per cycle with the quotient msb first
	assign q_bit   = (rem_q >= {1'b0, dvsr_q});
	assign rem_sub = q_bit ? (rem_q - {1'b0, dvsr_q}) : rem_q;

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sign_q   <= 1'b0;
			exp_a_q  <= '0;
			exp_b_q  <= '0;
			a_zero_q <= 1'b0;
			b_zero_q <= 1'b0;
			quo_q    <= '0;
		end else if (i_load) begin
			sign_q   <= i_a.sign ^ i_b.sign;
			exp_a_q  <= i_a.exp;
			exp_b_q  <= i_b.exp;
			a_zero_q <= ({i_a.exp, i_a.man} == '0);
			b_zero_q <= ({i_b.exp, i_b.man} == '0);
			quo_q    <= '0;
		end else if (i_step) begin
			quo_q <= {quo_q[SIG_W-1:0], q_bit};
		end
	end

	always_ff @(posedge clk) begin
		if (i_load) begin
			dvsr_q <= {1'b1, i_b.man};
			rem_q  <= {2'b01, i_a.man}; // dividend is the first partial remainder
		end else if (i_step) begin
			rem_q <= {rem_sub[SIG_W-1:0], 1'b0};
		end
	end

	// quotient lies in (1/2, 2) scaled by 2^24
	assign man_res = quo_q[SIG_W] ? quo_q[SIG_W-1:1] : quo_q[MAN_W-1:0];
	assign exp_res = XEXP_W'(exp_a_q) - XEXP_W'(exp_b_q) + XEXP_W'(EXP_BIAS)
		- XEXP_W'(!quo_q[SIG_W]);
	assign norm_res = pack_result(sign_q, exp_res, man_res);

	always_comb begin
		o_res = norm_res;
		if (b_zero_q) begin
			o_res           = '0;
			o_res.flags.zbz = a_zero_q;  // 0/0
			o_res.flags.dbz = !a_zero_q;
		end
	end

endmodule

/* mul/booth_mul.sv */
module booth_mul import fpu_pkg::*; (
	input  fp32_t      i_a,
	input  fp32_t      i_b,
	output fp_result_t o_res
);

	logic [2*SIG_W-1:0]       mcand;
	logic [2*SIG_W-1:0]       pp;
	logic [2*SIG_W-1:0]       prod;
	logic [SIG_W+2:0]         mr; // multiplier with two zero msbs and bit -1
	logic [2:0]               grp;
	logic                     hi;
	logic signed [XEXP_W-1:0] exp_res;
	logic [MAN_W-1:0]         man_res;

	always_comb begin
		mcand = {{SIG_W{1'b0}}, 1'b1, i_a.man};
		mr    = {2'b00, 1'b1, i_b.man, 1'b0};
		prod  = '0;
		for (int i = 0; i < PP_N; i++) begin
			grp = mr[2*i +: 3];
			case (grp)
				3'b001, 3'b010: pp = mcand;
				3'b011:         pp = mcand << 1;
				3'b100:         pp = -(mcand << 1);
				3'b101, 3'b110: pp = -mcand;
				default:        pp = '0; // 000 and 111
			endcase
			prod = prod + (pp << (2 * i));
		end
	end

	assign hi = prod[2*SIG_W-1]; // product in [2,4)

	assign man_res = hi ? prod[2*SIG_W-2 -: MAN_W] : prod[2*SIG_W-3 -: MAN_W];

	assign exp_res = XEXP_W'(i_a.exp) + XEXP_W'(i_b.exp) - XEXP_W'(EXP_BIAS) + XEXP_W'(hi);

	assign o_res = pack_result(i_a.sign ^ i_b.sign, exp_res, man_res);

endmodule

/* addsub/fp_addsub.sv */
module fp_addsub import fpu_pkg::*; (
	input  fp32_t      i_a,
	input  fp32_t      i_b,
	input  op_e        i_op,
	output fp_result_t o_res
);

	fp32_t                    b_eff;
	fp32_t                    mj;
	fp32_t                    mn;
	logic                     a_major;
	logic                     same_sign;
	logic                     cancel;
	logic [EXP_W-1:0]         exp_diff;
	logic [SIG_W-1:0]         sig_mj;
	logic [SIG_W-1:0]         sig_mn;
	logic [SIG_W-1:0]         sig_al;
	logic [SIG_W:0]           sum;
	logic [SIG_W-1:0]         dif;
	logic [SIG_W-1:0]         norm;
	logic [LZC_W-1:0]         lzc;
	logic signed [XEXP_W-1:0] exp_res;
	logic [MAN_W-1:0]         man_res;

	always_comb begin
		b_eff      = i_b;
		b_eff.sign = i_b.sign ^ (i_op == OP_SUB);

		// magnitude order compares exponent first then mantissa
		a_major   = {i_a.exp, i_a.man} >= {b_eff.exp, b_eff.man};
		mj        = a_major ? i_a : b_eff;
		mn        = a_major ? b_eff : i_a;
		same_sign = (mj.sign == mn.sign);
		cancel    = !same_sign && ({mj.exp, mj.man} == {mn.exp, mn.man});

		exp_diff = mj.exp - mn.exp;
		sig_mj   = {1'b1, mj.man};
		sig_mn   = {1'b1, mn.man};
		sig_al   = (exp_diff >= SIG_W) ? '0 : (sig_mn >> exp_diff); // everything shifted out

		sum = {1'b0, sig_mj} + {1'b0, sig_al};
		dif = sig_mj - sig_al;

		// highest set bit wins
		lzc = '0;
		for (int i = 0; i < SIG_W; i++) begin
			if (dif[i])
				lzc = LZC_W'(SIG_W - 1 - i);
		end
		norm = dif << lzc;

		if (same_sign) begin
			man_res = sum[SIG_W] ? sum[SIG_W-1:1] : sum[MAN_W-1:0]; // carry out moves right
			exp_res = XEXP_W'(mj.exp) + XEXP_W'(sum[SIG_W]);
		end else begin
			man_res = norm[MAN_W-1:0];
			exp_res = XEXP_W'(mj.exp) - XEXP_W'(lzc);
		end

		// exact cancellation gives +0 without a flag
		if (cancel)
			o_res = '0;
		else
			o_res = pack_result(mj.sign, exp_res, man_res);
	end

endmodule

/* hdl/fpu_ctrl.sv */
module fpu_ctrl import fpu_pkg::*; (
	input  logic clk,
	input  logic i_arst_n,
	input  logic i_start,
	input  op_e  i_op,
	input  logic i_last,
	output logic o_load,
	output logic o_step,
	output logic o_capture,
	output op_e  o_sel,
	output logic o_busy
);

	ctrl_state_e state_q;
	ctrl_state_e state_d;
	op_e         sel_q;
	logic        start_ok;

	assign start_ok = i_start && (state_q == ST_IDLE); // starts while busy are dropped

	assign o_load    = start_ok && (i_op == OP_DIV);
	assign o_step    = (state_q == ST_DIVIDE);
	assign o_capture = (start_ok && (i_op != OP_DIV)) || (state_q == ST_FINISH);
	assign o_sel     = (state_q == ST_IDLE) ? i_op : sel_q; // single-cycle ops pass straight
	assign o_busy    = (state_q != ST_IDLE);

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE:   if (o_load) state_d = ST_DIVIDE;
			ST_DIVIDE: if (o_step && i_last) state_d = ST_FINISH;
			ST_FINISH: state_d = ST_IDLE;
			default:   state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state_q <= ST_IDLE;
			sel_q   <= OP_ADD;
		end else begin
			state_q <= state_d;
			if (o_load)
				sel_q <= OP_DIV; // held for the capture in ST_FINISH
		end
	end

endmodule

/* hdl/iter_counter.sv */
module iter_counter import fpu_pkg::*; (
	input  logic clk,
	input  logic i_arst_n,
	input  logic i_clear,
	input  logic i_en,
	output logic o_last
);

	logic [CNT_W-1:0] cnt_q;

	assign o_last = (cnt_q == CNT_W'(DIV_ITER - 1));

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n)
			cnt_q <= '0;
		else if (i_clear)
			cnt_q <= '0;
		else if (i_en && !o_last)
			cnt_q <= cnt_q + 1'b1; // parks on the last value
	end

endmodule

/* common/fpu_pkg.sv */
package fpu_pkg;

	localparam int EXP_W    = 8;
	localparam int MAN_W    = 23;
	localparam int SIG_W    = 24; // mantissa plus implicit one
	localparam int EXP_BIAS = 127;
	localparam int EXP_MAX  = 254; // largest finite exponent

	localparam int DIV_ITER = 25;
	localparam int CNT_W    = 5;

	localparam int PP_N   = 13; // radix-4 booth partial products
	localparam int LZC_W  = 5;
	localparam int XEXP_W = EXP_W + 2; // exponent with sign and carry room

	typedef struct packed {
		logic             sign;
		logic [EXP_W-1:0] exp;
		logic [MAN_W-1:0] man;
	} fp32_t;

	typedef struct packed {
		logic ovf;
		logic unf;
		logic dbz;
		logic zbz;
	} fp_flags_t;

	typedef struct packed {
		fp32_t     val;
		fp_flags_t flags;
	} fp_result_t;

	typedef enum logic [1:0] {
		OP_ADD = 2'd0,
		OP_SUB = 2'd1,
		OP_MUL = 2'd2,
		OP_DIV = 2'd3
	} op_e;

	typedef enum logic [1:0] {
		ST_IDLE   = 2'd0,
		ST_DIVIDE = 2'd1,
		ST_FINISH = 2'd2
	} ctrl_state_e;

	// saturates an out-of-range wide exponent to inf or signed zero
	function automatic fp_result_t pack_result(
		input logic                     sign,
		input logic signed [XEXP_W-1:0] exp,
		input logic [MAN_W-1:0]         man
	);
		fp_result_t res;
		res          = '0;
		res.val.sign = sign;
		if (exp > EXP_MAX) begin
			res.val.exp   = '1; // mantissa stays 0
			res.flags.ovf = 1'b1;
		end else if (exp < 1) begin
			res.flags.unf = 1'b1;
		end else begin
			res.val.exp = exp[EXP_W-1:0];
			res.val.man = man;
		end
		return res;
	endfunction

endpackage
